//--- Bender.yml
package:
  name: bongo

sources:
  - include_dirs:
      - include
    files:
      - logic/bongoPkg.sv
      - logic/pollTimer.sv
      - logic/pollSender.sv
      - logic/pulseReceiver.sv
      - logic/hitDecoder.sv
      - logic/bongoTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/bongoChecker.sv
      - tests/bongoTb.sv

//--- include/bongo_macros.svh
`ifndef BONGO_MACROS_SVH
`define BONGO_MACROS_SVH

// clk cycles per line chip
`define BONGO_CHIP_CYCLES 8

// clk cycles between poll starts
`define BONGO_POLL_INTERVAL 6000

// poll command, sent msb first and followed by a stop 1
`define BONGO_CMD_BITS 24
`define BONGO_POLL_CMD 24'h400302

// response frame length in bits
`define BONGO_RESP_BITS 64

// low time below this many cycles reads as a 1
`define BONGO_SHORT_LOW 16

// idle cycles before a partial response is dropped
`define BONGO_RESP_TIMEOUT 64

// hit values above this are halved
`define BONGO_HIT_LIMIT 8'h35

`endif

//--- logic/bongoPkg.sv
`include "bongo_macros.svh"

package bongoPkg;

	// full controller response, bit 63 arrives first
	typedef logic [`BONGO_RESP_BITS-1:0] respFrame;

	// raw or scaled hit value from the top response byte
	typedef logic [7:0] hitByte;

	// microphone level from the low response bits
	typedef logic [11:0] micLevel;

	// one hex digit of the hit display
	typedef logic [3:0] hexDigit;

	// active high segments, bit 0 is segment a
	// bit 7 is the decimal point and stays off
	typedef logic [7:0] segPattern;

	// poll sender FSM
	typedef enum logic {
		senderIdle,
		senderSending
	} senderState;

endpackage

//--- logic/bongoTop.sv
`timescale 1ns/1ps

module bongoTop (
	input logic clk,
	input logic rstN,
	input logic lineIn,
	output logic lineDriveLow,
	output logic polling,
	output logic frameValid,
	output logic respTimeout,
	output bongoPkg::hexDigit dig0,
	output bongoPkg::hexDigit dig1,
	output bongoPkg::segPattern seg0,
	output bongoPkg::segPattern seg1,
	output bongoPkg::micLevel mic
);

	import bongoPkg::*;

	logic pollStart;
	logic sendDone;
	respFrame frame;

	// poll cadence
	pollTimer timer (
		.clk(clk),
		.rstN(rstN),
		.pollStart(pollStart)
	);

	// command out on the line, polling is high while it runs
	pollSender sender (
		.clk(clk),
		.rstN(rstN),
		.pollStart(pollStart),
		.lineDriveLow(lineDriveLow),
		.sendDone(sendDone),
		.sending(polling)
	);

	// response back from the controller
	pulseReceiver receiver (
		.clk(clk),
		.rstN(rstN),
		.lineIn(lineIn),
		.sendDone(sendDone),
		.frame(frame),
		.frameValid(frameValid),
		.respTimeout(respTimeout)
	);

	hitDecoder decoder (
		.clk(clk),
		.rstN(rstN),
		.frameValid(frameValid),
		.frame(frame),
		.dig0(dig0),
		.dig1(dig1),
		.seg0(seg0),
		.seg1(seg1),
		.mic(mic)
	);

endmodule

//--- logic/hitDecoder.sv
`timescale 1ns/1ps

`include "bongo_macros.svh"

module hitDecoder (
	input logic clk,
	input logic rstN,
	input logic frameValid,
	input bongoPkg::respFrame frame,
	output bongoPkg::hexDigit dig0,
	output bongoPkg::hexDigit dig1,
	output bongoPkg::segPattern seg0,
	output bongoPkg::segPattern seg1,
	output bongoPkg::micLevel mic
);

	import bongoPkg::*;

	localparam hitByte HitLimit = `BONGO_HIT_LIMIT;
	localparam int RespBits = `BONGO_RESP_BITS;

	hitByte hitRaw;
	hitByte hitVal;

	// hex to seven segments, segment a in bit 0
	function automatic segPattern hexToSeg(input hexDigit value);
		case (value)
			4'h0: return 8'h3F;
			4'h1: return 8'h06;
			4'h2: return 8'h5B;
			4'h3: return 8'h4F;
			4'h4: return 8'h66;
			4'h5: return 8'h6D;
			4'h6: return 8'h7D;
			4'h7: return 8'h07;
			4'h8: return 8'h7F;
			4'h9: return 8'h6F;
			4'hA: return 8'h77;
			4'hB: return 8'h7C;
			4'hC: return 8'h39;
			4'hD: return 8'h5E;
			4'hE: return 8'h79;
			default: return 8'h71;
		endcase
	endfunction

	// top byte is the hit, large values get halved
	assign hitRaw = frame[RespBits-1 -: 8];
	assign hitVal = (hitRaw > HitLimit) ? (hitRaw >> 1) : hitRaw;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dig0 <= '0;
			dig1 <= '0;
			seg0 <= hexToSeg(4'h0);
			seg1 <= hexToSeg(4'h0);
			mic <= '0;
		end else if (frameValid) begin
			dig1 <= hitVal[7:4];
			dig0 <= hitVal[3:0];
			seg1 <= hexToSeg(hitVal[7:4]);
			seg0 <= hexToSeg(hitVal[3:0]);
			mic <= frame[$bits(micLevel)-1:0];
		end
	end

endmodule

//--- logic/pollSender.sv
`timescale 1ns/1ps

`include "bongo_macros.svh"

module pollSender (
	input logic clk,
	input logic rstN,
	input logic pollStart,
	output logic lineDriveLow,
	output logic sendDone,
	output logic sending
);

	import bongoPkg::*;

	localparam int ChipCycles = `BONGO_CHIP_CYCLES;
	localparam int PollBits = `BONGO_CMD_BITS + 1;
	localparam int PollChips = 4 * PollBits;
	localparam int CycleWidth = (ChipCycles > 2) ? $clog2(ChipCycles) : 1;

	// command followed by the stop bit
	localparam logic [PollBits-1:0] PollWord = {`BONGO_POLL_CMD, 1'b1};

	senderState state;
	logic [CycleWidth-1:0] chipCycle;
	logic [6:0] chipIdx;
	logic [4:0] bitIdx;
	logic curBit;
	logic chipLow;
	logic lastCycle;
	logic lastChip;

	// four chips per bit
	assign bitIdx = chipIdx[6:2];
	assign curBit = PollWord[5'(PollBits - 1) - bitIdx];

	// 0 is low low low high, 1 is low high high high
	assign chipLow = (chipIdx[1:0] == 2'd0) || (!curBit && chipIdx[1:0] != 2'd3);

	assign lastCycle = chipCycle == CycleWidth'(ChipCycles - 1);
	assign lastChip = chipIdx == 7'(PollChips - 1);

	assign sending = state == senderSending;
	// open drain, only ever pull low
	assign lineDriveLow = sending && chipLow;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= senderIdle;
			chipCycle <= '0;
			chipIdx <= '0;
			sendDone <= 1'b0;
		end else begin
			sendDone <= 1'b0;
			case (state)
				senderIdle: begin
					if (pollStart) begin
						state <= senderSending;
						chipCycle <= '0;
						chipIdx <= '0;
					end
				end
				senderSending: begin
					// pollStart has no effect here
					if (lastCycle) begin
						chipCycle <= '0;
						if (lastChip) begin
							state <= senderIdle;
							sendDone <= 1'b1;
						end else begin
							chipIdx <= chipIdx + 7'd1;
						end
					end else begin
						chipCycle <= chipCycle + 1'b1;
					end
				end
				default: begin
					state <= senderIdle;
				end
			endcase
		end
	end

endmodule

//--- logic/pollTimer.sv
`timescale 1ns/1ps

`include "bongo_macros.svh"

module pollTimer (
	input logic clk,
	input logic rstN,
	output logic pollStart
);

	localparam int Interval = `BONGO_POLL_INTERVAL;
	localparam int CountWidth = (Interval > 2) ? $clog2(Interval) : 1;

	logic [CountWidth-1:0] count;
	logic wrap;

	// last cycle of the interval
	assign wrap = count == CountWidth'(Interval - 1);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			count <= '0;
		end else if (wrap) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// registered strobe, first one lands a full interval after reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pollStart <= 1'b0;
		end else begin
			pollStart <= wrap;
		end
	end

endmodule

//--- logic/pulseReceiver.sv
`timescale 1ns/1ps

`include "bongo_macros.svh"

module pulseReceiver (
	input logic clk,
	input logic rstN,
	input logic lineIn,
	input logic sendDone,
	output bongoPkg::respFrame frame,
	output logic frameValid,
	output logic respTimeout
);

	localparam int ShortLow = `BONGO_SHORT_LOW;
	localparam int Timeout = `BONGO_RESP_TIMEOUT;
	localparam int RespBits = `BONGO_RESP_BITS;
	localparam int LowWidth = $clog2(ShortLow) + 1;
	localparam int IdleWidth = $clog2(Timeout) + 1;
	localparam int CountWidth = $clog2(RespBits) + 1;

	logic lineMeta;
	logic lineSync;
	logic linePrev;
	logic fallEdge;
	logic riseEdge;
	logic armed;
	logic [LowWidth-1:0] lowCount;
	logic [IdleWidth-1:0] idleCount;
	logic [CountWidth-1:0] bitCount;
	logic bitVal;
	logic lastBit;
	logic idleExpired;

	// two flop sync, line idles high
	always_ff @(posedge clk) begin
		if (!rstN) begin
			lineMeta <= 1'b1;
			lineSync <= 1'b1;
			linePrev <= 1'b1;
		end else begin
			lineMeta <= lineIn;
			lineSync <= lineMeta;
			linePrev <= lineSync;
		end
	end

	assign fallEdge = linePrev && !lineSync;
	assign riseEdge = !linePrev && lineSync;

	// short low pulse means a 1
	assign bitVal = lowCount < LowWidth'(ShortLow);
	assign lastBit = bitCount == CountWidth'(RespBits - 1);
	assign idleExpired = idleCount == IdleWidth'(Timeout - 1);

	// low time, saturating so long lows cannot wrap into a 1
	always_ff @(posedge clk) begin
		if (!rstN) begin
			lowCount <= '0;
		end else if (fallEdge) begin
			lowCount <= LowWidth'(1);
		end else if (!lineSync && lowCount != '1) begin
			lowCount <= lowCount + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			armed <= 1'b0;
			bitCount <= '0;
			idleCount <= '0;
			frameValid <= 1'b0;
			respTimeout <= 1'b0;
		end else begin
			frameValid <= 1'b0;
			respTimeout <= 1'b0;
			if (sendDone) begin
				armed <= 1'b1;
				bitCount <= '0;
				idleCount <= '0;
			end else if (armed) begin
				// any edge restarts the idle count
				if (fallEdge || riseEdge) begin
					idleCount <= '0;
				end else if (idleExpired) begin
					armed <= 1'b0;
					bitCount <= '0;
					respTimeout <= 1'b1;
				end else begin
					idleCount <= idleCount + 1'b1;
				end

				if (riseEdge) begin
					// disarm after the last bit so the stop pulse is ignored
					if (lastBit) begin
						armed <= 1'b0;
						bitCount <= '0;
						frameValid <= 1'b1;
					end else begin
						bitCount <= bitCount + 1'b1;
					end
				end
			end
		end
	end

	// msb arrives first
	always_ff @(posedge clk) begin
		if (armed && riseEdge) begin
			frame <= {frame[RespBits-2:0], bitVal};
		end
	end

endmodule

//--- sim.f
+incdir+include
logic/bongoPkg.sv
logic/pollTimer.sv
logic/pollSender.sv
logic/pulseReceiver.sv
logic/hitDecoder.sv
logic/bongoTop.sv
tests/bongoChecker.sv
tests/bongoTb.sv

//--- tests/bongoChecker.sv
`timescale 1ns/1ps

`include "bongo_macros.svh"

module bongoChecker (
	input logic clk,
	input logic rstN,
	input logic lineDriveLow,
	input logic polling,
	input logic frameValid,
	input logic respTimeout,
	input bongoPkg::hexDigit dig0,
	input bongoPkg::hexDigit dig1,
	input bongoPkg::segPattern seg0,
	input bongoPkg::segPattern seg1,
	input bongoPkg::micLevel mic,
	input bongoPkg::respFrame expFrame,
	input logic expSilent,
	output int errorCount,
	output int testCount
);

	import bongoPkg::*;

	localparam int ChipCycles = `BONGO_CHIP_CYCLES;
	localparam int Interval = `BONGO_POLL_INTERVAL;
	localparam int PollBits = `BONGO_CMD_BITS + 1;
	localparam int PollChips = 4 * PollBits;
	// hex font with digit f in the top byte and segment a in bit 0
	localparam logic [127:0] SegFont = 128'h71795E397C776F7F077D6D664F5B063F;

	logic pollPrev;
	logic pending;
	logic timeoutPending;
	bit testOk;
	int cycleNow;
	int lastRise;
	int pollCycle;
	int pollCount;
	logic [PollChips-1:0] chips;
	respFrame heldFrame;

	// first chip in the msb
	// set bits mark chips that pull the line low
	function automatic logic [PollChips-1:0] expectedChips();
		logic [PollBits-1:0] word;
		logic [PollChips-1:0] c;
		int b;
		word = {`BONGO_POLL_CMD, 1'b1};
		for (b = 0; b < PollBits; b++) begin
			c[PollChips - 1 - 4 * b -: 4] = word[PollBits - 1 - b] ? 4'b1000 : 4'b1110;
		end
		return c;
	endfunction

	// dig1, dig0, seg1, seg0, mic
	function automatic logic [35:0] expectedOutputs(input respFrame f);
		hitByte hit;
		hit = f[63:56];
		if (hit > `BONGO_HIT_LIMIT) begin
			hit = hit >> 1;
		end
		return {hit[7:4], hit[3:0], SegFont[int'(hit[7:4]) * 8 +: 8],
			SegFont[int'(hit[3:0]) * 8 +: 8], f[11:0]};
	endfunction

	task automatic checkField(input string name, input logic [15:0] expVal,
			input logic [15:0] gotVal);
		if (gotVal !== expVal) begin
			$display("Fail %s expected %h got %h", name, expVal, gotVal);
			errorCount++;
			testOk = 0;
		end
	endtask

	task automatic compareOutputs(input respFrame f, input string label);
		logic [35:0] e;
		e = expectedOutputs(f);
		testOk = 1;
		checkField("dig1", e[35:32], dig1);
		checkField("dig0", e[31:28], dig0);
		checkField("seg1", e[27:20], seg1);
		checkField("seg0", e[19:12], seg0);
		checkField("mic", e[11:0], mic);
		testCount++;
		$display("%s after poll %0d, frame %h: %s", label, pollCount, f,
			testOk ? "ok" : "mismatch");
	endtask

	task automatic finishPoll();
		pollCount++;
		checkField("polling length", 16'(PollChips * ChipCycles), 16'(pollCycle));
		if (chips !== expectedChips()) begin
			$display("Fail lineDriveLow chips expected %h got %h", expectedChips(), chips);
			errorCount++;
			testOk = 0;
		end
		testCount++;
		$display("poll %0d: %0d chips, %s", pollCount, pollCycle / ChipCycles,
			testOk ? "ok" : "mismatch");
	endtask

	always @(negedge clk) begin
		if (!rstN) begin
			pollPrev = 1'b0;
			pending = 1'b0;
			timeoutPending = 1'b0;
			cycleNow = 0;
			lastRise = -1;
			pollCycle = 0;
			pollCount = 0;
			heldFrame = '0;
			errorCount = 0;
			testCount = 0;
		end else begin
			cycleNow++;
			if (polling && !pollPrev) begin
				testOk = 1;
				pollCycle = 0;
				chips = '0;
				if (lastRise >= 0) begin
					checkField("polling interval", 16'(Interval), 16'(cycleNow - lastRise));
				end
				lastRise = cycleNow;
			end
			// sample each chip in its middle
			if (polling) begin
				if (pollCycle % ChipCycles == ChipCycles / 2 &&
						pollCycle < PollChips * ChipCycles) begin
					chips[PollChips - 1 - pollCycle / ChipCycles] = lineDriveLow;
				end
				pollCycle++;
			end else if (lineDriveLow) begin
				$display("Error: line pulled low while no poll is running");
				errorCount++;
			end
			if (!polling && pollPrev) begin
				finishPoll();
			end
			pollPrev = polling;

			// decoder outputs settle one cycle after frameValid
			if (pending) begin
				compareOutputs(expFrame, "response");
				heldFrame = expFrame;
				pending = 1'b0;
			end
			// outputs must still show the last good frame after the timeout
			if (timeoutPending) begin
				compareOutputs(heldFrame, "timeout");
				timeoutPending = 1'b0;
			end
			if (frameValid) begin
				if (expSilent) begin
					$display("Error: frameValid pulsed although the controller stayed silent");
					errorCount++;
				end else begin
					pending = 1'b1;
				end
			end
			if (respTimeout) begin
				if (expSilent) begin
					timeoutPending = 1'b1;
				end else begin
					$display("Error: respTimeout pulsed while the controller was answering");
					errorCount++;
				end
			end
		end
	end

endmodule

//--- tests/bongoTb.sv
`timescale 1ns/1ps

`include "bongo_macros.svh"

module bongoTb;

	import bongoPkg::*;

	localparam int ChipCycles = `BONGO_CHIP_CYCLES;
	localparam int PollCycles = 4 * (`BONGO_CMD_BITS + 1) * ChipCycles;
	localparam int NumPolls = 12;
	localparam int SilentPoll = 5;
	localparam int FirstForced = 9;

	logic clk;
	logic rstN;
	logic modelLow;
	logic lineIn;
	logic lineDriveLow;
	logic polling;
	logic frameValid;
	logic respTimeout;
	hexDigit dig0;
	hexDigit dig1;
	segPattern seg0;
	segPattern seg1;
	micLevel mic;
	respFrame expFrame;
	logic expSilent;
	int errorCount;
	int testCount;
	logic [31:0] seed;
	bit aborted;
	logic pollingPrev = 1'b0;
	// poll starts, poll ends, responses
	int events [3] = '{0, 0, 0};

	// wired line, either side may pull it low
	assign lineIn = !(lineDriveLow || modelLow);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	bongoTop uut (.*);

	bongoChecker outputCheck (.*);

	always @(negedge clk) begin
		pollingPrev <= polling;
		if (polling && !pollingPrev) events[0] <= events[0] + 1;
		if (!polling && pollingPrev) events[1] <= events[1] + 1;
		if (frameValid || respTimeout) events[2] <= events[2] + 1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// low for lowChips, then released for highChips
	task automatic sendPulse(input int lowChips, input int highChips);
		modelLow = 1'b1;
		repeat (lowChips * ChipCycles) @(negedge clk);
		modelLow = 1'b0;
		repeat (highChips * ChipCycles) @(negedge clk);
	endtask

	task automatic sendFrame(input respFrame f);
		int b;
		repeat (3 * ChipCycles) @(negedge clk);
		for (b = `BONGO_RESP_BITS - 1; b >= 0; b--) begin
			if (f[b]) sendPulse(1, 3);
			else sendPulse(3, 1);
		end
		// stop pulse, arrives after the receiver has its 64 bits
		sendPulse(1, 1);
	endtask

	task automatic waitForEvent(input int which, input int target, input int limit,
			input string what, output bit ok);
		int n;
		n = 0;
		while (events[which] < target && n < limit) begin
			@(negedge clk);
			n++;
		end
		ok = events[which] >= target;
		if (!ok) $display("Timeout: no %s within %0d cycles", what, limit);
	endtask

	initial begin
		int i;
		bit ok;
		respFrame frame;
		rstN = 1'b0;
		modelLow = 1'b0;
		expFrame = '0;
		expSilent = 1'b0;
		seed = 32'h8a65;
		aborted = 1'b0;
		repeat (16) @(negedge clk);
		rstN = 1'b1;

		for (i = 0; i < NumPolls && !aborted; i++) begin
			waitForEvent(0, i + 1, `BONGO_POLL_INTERVAL + 100, "poll start", ok);
			if (ok) waitForEvent(1, i + 1, PollCycles + 100, "poll end", ok);
			if (ok) begin
				seed = xorshift(seed);
				frame[63:32] = seed;
				seed = xorshift(seed);
				frame[31:0] = seed;
				// hit byte at or below the limit, or forced above it
				if (i >= FirstForced) frame[63:56] = 8'h36 + frame[63:56] % 8'hCA;
				else frame[63:56] = frame[63:56] % 8'h36;
				if (i == 0) frame[63:56] = 8'h35;
				if (i == FirstForced) frame[63:56] = 8'h36;
				expFrame = frame;
				expSilent = (i == SilentPoll);
				if (!expSilent) sendFrame(frame);
				waitForEvent(2, i + 1, 3000, "response or response timeout", ok);
			end
			aborted = !ok;
		end

		repeat (4) @(negedge clk);
		if (!aborted && testCount != 2 * NumPolls) begin
			$display("Only %0d of %0d tests completed", testCount, 2 * NumPolls);
		end
		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (aborted || errorCount != 0 || testCount != 2 * NumPolls) begin
			$display("Simulation failed");
		end else begin
			$display("Simulation passed");
		end
		$finish;
	end

endmodule
